// File: fetch_patterns.txt
# T name: new test with reset, L addr data: sram preload word
# E pc inst: expected fetch in order, D halted fault: start, then end flags
T redirect_halt
L 80000000 00100093
L 80000004 00200113
L 80000008 0180006F
L 8000000C 002081B3
L 80000010 0200006F
L 80000020 00208463
L 80000024 FE2094E3
L 80000028 00100073
L 80000030 FF9FF06F
E 80000000 00100093
E 80000004 00200113
E 80000008 0180006F
E 80000020 00208463
E 80000024 FE2094E3
E 8000000C 002081B3
E 80000010 0200006F
E 80000030 FF9FF06F
E 80000028 00100073
D 1 0
# jal past the end of the sram
T bad_target_fault
L 80000000 00100093
L 80000004 1000006F
E 80000000 00100093
E 80000004 1000006F
D 0 1

// File: all.f
rv_isa_pkg.sv
bus_pkg.sv
fetch_ctrl.sv
inst_sram.sv
next_pc_unit.sv
fetch_top.sv
fetch_checker.sv
tb_fetch.sv

// File: Bender.yml
package:
  name: fetch_subsystem

sources:
  - rv_isa_pkg.sv
  - bus_pkg.sv
  - fetch_ctrl.sv
  - inst_sram.sv
  - next_pc_unit.sv
  - fetch_top.sv
  - target: simulation
    files:
      - fetch_checker.sv
      - tb_fetch.sv

// File: tb_fetch.sv
module tb_fetch;

    logic        clk = 1'b0;
    logic        rst;
    logic        start;
    logic        load_en;
    logic [31:0] load_addr;
    logic [31:0] load_data;
    logic        inst_valid;
    logic [31:0] inst_pc;
    logic [31:0] inst;
    logic        halted;
    logic        fault;

    logic        loading;    // sram preload in progress
    logic        end_check;  // run settled, checker looks at end flags
    int          test_idx;
    int          mismatch_errs;
    int          other_errs;
    int          tb_errs   = 0;
    bit          timed_out = 1'b0;

    always #2 clk = ~clk; // period 4

    fetch_top fetch_top_i (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .inst_valid (inst_valid),
        .inst_pc    (inst_pc),
        .inst       (inst),
        .halted     (halted),
        .fault      (fault)
    );

    fetch_checker fetch_checker_i (
        .clk           (clk),
        .rst           (rst),
        .inst_valid    (inst_valid),
        .inst_pc       (inst_pc),
        .inst          (inst),
        .halted        (halted),
        .fault         (fault),
        .loading       (loading),
        .end_check     (end_check),
        .test_idx      (test_idx),
        .mismatch_errs (mismatch_errs),
        .other_errs    (other_errs)
    );

    // 8 cycles of reset before each test, sram contents survive
    task automatic apply_reset(input int idx);
        @(posedge clk);
        rst      <= 1'b1;
        loading  <= 1'b1;
        test_idx <= idx;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic load_word(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        load_en   <= 1'b1;
        load_addr <= addr;
        load_data <= data;
    endtask

    task automatic run_program();
        int cycles;
        cycles = 0;
        @(posedge clk);
        load_en <= 1'b0;
        loading <= 1'b0;
        start   <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk); // flags sampled mid-cycle
        while (!halted && !fault && !timed_out) begin
            @(negedge clk);
            cycles++;
            if (cycles >= 2000) begin
                $display("timeout: neither halted nor fault after 2000 cycles");
                timed_out = 1'b1;
                tb_errs++;
            end
        end
        repeat (10) @(posedge clk); // window for strobes after the stop
        @(posedge clk);
        end_check <= 1'b1;
        @(posedge clk);
        end_check <= 1'b0;
    endtask

    initial begin : stimulus
        int              fd;
        int              n;
        int              idx;
        logic [8*80-1:0] line;
        logic [8*16-1:0] tag;
        logic [8*24-1:0] tname;
        logic [31:0]     a;
        logic [31:0]     d;
        rst       = 1'b1;
        start     = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        loading   = 1'b1;
        end_check = 1'b0;
        test_idx  = -1;
        idx       = -1;
        fd = $fopen("fetch_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open fetch_patterns.txt");
            tb_errs++;
        end else begin
            while (!$feof(fd) && !timed_out) begin
                line = '0;
                tag  = '0;
                n    = $fgets(line, fd);
                if (n > 0) n = $sscanf(line, "%s %h %h", tag, a, d);
                if (tag == "T") begin
                    n = $sscanf(line, "%s %s", tag, tname);
                    idx++;
                    $display("test %0d: %0s", idx, tname);
                    apply_reset(idx);
                end else if (tag == "L") begin
                    load_word(a, d);
                end else if (tag == "D") begin
                    run_program();
                end
            end
            $fclose(fd);
        end
        @(posedge clk); // let the checker finish its last compare
        @(posedge clk);
        $display("errors: %0d mismatch, %0d other, %0d testbench",
                 mismatch_errs, other_errs, tb_errs);
        if (mismatch_errs == 0 && other_errs == 0 && tb_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: fetch_checker.sv
module fetch_checker #(
    parameter int max_exp   = 64,
    parameter int max_tests = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        inst_valid,
    input  logic [31:0] inst_pc,
    input  logic [31:0] inst,
    input  logic        halted,
    input  logic        fault,
    input  logic        loading,    // preload phase, start not given yet
    input  logic        end_check,  // run has settled, check the end state
    input  int          test_idx,
    output int          mismatch_errs,
    output int          other_errs
);

    logic [31:0]     exp_pc     [max_exp];
    logic [31:0]     exp_inst   [max_exp];
    int              exp_test   [max_exp];  // owning test of each trace record
    logic [8*24-1:0] test_name  [max_tests];
    logic            end_halted [max_tests];
    logic            end_fault  [max_tests];

    int n_exp      = 0;
    int ptr        = 0;  // next expected record
    int seq        = 0;  // position inside the current test
    int n_mismatch = 0;
    int n_other    = 0;
    int file_errs  = 0;

    assign mismatch_errs = n_mismatch;
    assign other_errs    = n_other + file_errs;

    function automatic logic [8*24-1:0] name_of(int t);
        if (t < 0 || t >= max_tests) return "none";
        return test_name[t];
    endfunction

    // expected trace and end flags, same file the stimulus comes from
    initial begin : read_trace
        int              fd;
        int              n;
        int              t;
        logic [8*80-1:0] line;
        logic [8*16-1:0] tag;
        logic [31:0]     a;
        logic [31:0]     b;
        t  = -1;
        fd = $fopen("fetch_patterns.txt", "r");
        if (fd == 0) begin
            $display("checker could not open fetch_patterns.txt");
            file_errs = 1;
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                tag  = '0;
                n    = $fgets(line, fd);
                if (n > 0) n = $sscanf(line, "%s %h %h", tag, a, b);
                if (tag == "T" && t < max_tests - 1) begin
                    t = t + 1;
                    n = $sscanf(line, "%s %s", tag, test_name[t]);
                    end_halted[t] = 1'b0;
                    end_fault[t]  = 1'b0;
                end else if (tag == "E" && t >= 0 && n_exp < max_exp) begin
                    exp_pc[n_exp]   = a;
                    exp_inst[n_exp] = b;
                    exp_test[n_exp] = t;
                    n_exp = n_exp + 1;
                end else if (tag == "D" && t >= 0) begin
                    end_halted[t] = a[0];
                    end_fault[t]  = b[0];
                end
            end
            $fclose(fd);
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            // nothing may come out while the sram is being filled
            if (loading && (inst_valid || halted || fault)) begin
                $display("output active before start: valid %b halted %b fault %b",
                         inst_valid, halted, fault);
                n_other = n_other + 1;
            end
            if (inst_valid) begin
                if (ptr >= n_exp || exp_test[ptr] != test_idx) begin
                    $display("extra instruction in %0s: pc %h inst %h",
                             name_of(test_idx), inst_pc, inst);
                    n_other = n_other + 1;
                end else begin
                    if (inst_pc !== exp_pc[ptr]) begin
                        $display("CHECK FAILED %0s inst_pc[%0d]: expected %h actual %h",
                                 name_of(test_idx), seq, exp_pc[ptr], inst_pc);
                        n_mismatch = n_mismatch + 1;
                    end
                    if (inst !== exp_inst[ptr]) begin
                        $display("CHECK FAILED %0s inst[%0d]: expected %h actual %h",
                                 name_of(test_idx), seq, exp_inst[ptr], inst);
                        n_mismatch = n_mismatch + 1;
                    end
                    ptr = ptr + 1;
                    seq = seq + 1;
                end
            end
            if (end_check) begin
                // whatever is left of this test never came out
                while (ptr < n_exp && exp_test[ptr] == test_idx) begin
                    $display("missing instruction in %0s: pc %h inst %h was never issued",
                             name_of(test_idx), exp_pc[ptr], exp_inst[ptr]);
                    n_other = n_other + 1;
                    ptr = ptr + 1;
                end
                if (halted !== end_halted[test_idx]) begin
                    $display("CHECK FAILED %0s halted: expected %b actual %b",
                             name_of(test_idx), end_halted[test_idx], halted);
                    n_mismatch = n_mismatch + 1;
                end
                if (fault !== end_fault[test_idx]) begin
                    $display("CHECK FAILED %0s fault: expected %b actual %b",
                             name_of(test_idx), end_fault[test_idx], fault);
                    n_mismatch = n_mismatch + 1;
                end
                seq = 0;
            end
        end
    end

endmodule

// File: fetch_top.sv
module fetch_top #(
    parameter logic [31:0] reset_pc     = 32'h8000_0000,
    parameter logic [31:0] mem_base     = 32'h8000_0000,
    parameter int          mem_words    = 64,
    parameter int          sram_latency = 3
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    // sram preload
    input  logic                        load_en,
    input  logic [bus_pkg::addr_w-1:0]  load_addr,
    input  logic [bus_pkg::data_w-1:0]  load_data,
    // fetched instruction strobe
    output logic                        inst_valid,
    output logic [rv_isa_pkg::xlen-1:0] inst_pc,
    output logic [rv_isa_pkg::xlen-1:0] inst,
    output logic                        halted,
    output logic                        fault
);

    // read bus
    logic [bus_pkg::addr_w-1:0]  araddr;
    logic                        arvalid;
    logic                        arready;
    logic                        rvalid;
    logic                        rready;
    logic [bus_pkg::data_w-1:0]  rdata;
    logic [bus_pkg::resp_w-1:0]  rresp;

    // controller to pc unit
    logic [rv_isa_pkg::xlen-1:0] pc;
    logic [rv_isa_pkg::xlen-1:0] inst_word;
    logic                        advance;
    logic                        is_ebreak;

    fetch_ctrl fetch_ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .rresp      (rresp),
        .pc         (pc),
        .is_ebreak  (is_ebreak),
        .inst_word  (inst_word),
        .advance    (advance),
        .inst_valid (inst_valid),
        .inst_pc    (inst_pc),
        .inst       (inst),
        .halted     (halted),
        .fault      (fault)
    );

    inst_sram #(
        .mem_base     (mem_base),
        .mem_words    (mem_words),
        .sram_latency (sram_latency)
    ) inst_sram_i (
        .clk       (clk),
        .rst       (rst),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rvalid    (rvalid),
        .rready    (rready),
        .rdata     (rdata),
        .rresp     (rresp),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

    next_pc_unit #(
        .reset_pc (reset_pc)
    ) next_pc_unit_i (
        .clk       (clk),
        .rst       (rst),
        .advance   (advance),
        .inst_word (inst_word),
        .pc        (pc),
        .next_pc   (),
        .is_ebreak (is_ebreak)
    );

endmodule

// File: next_pc_unit.sv
module next_pc_unit #(
    parameter logic [rv_isa_pkg::xlen-1:0] reset_pc = 32'h8000_0000
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        advance,   // one-cycle pulse from fetch_ctrl
    input  logic [rv_isa_pkg::xlen-1:0] inst_word,
    output logic [rv_isa_pkg::xlen-1:0] pc,
    output logic [rv_isa_pkg::xlen-1:0] next_pc,
    output logic                        is_ebreak
);

    rv_isa_pkg::inst_word_u      w;
    logic [rv_isa_pkg::xlen-1:0] imm_j;
    logic [rv_isa_pkg::xlen-1:0] imm_b;
    logic                        is_jal;
    logic                        is_branch;
    logic                        take_branch;

    assign w = inst_word;

    assign imm_j = rv_isa_pkg::j_imm(w);
    assign imm_b = rv_isa_pkg::b_imm(w);

    // opcode sits in the same bits in both views
    assign is_jal    = (w.j_view.opcode == rv_isa_pkg::op_jal);
    assign is_branch = (w.b_view.opcode == rv_isa_pkg::op_branch)
                       && rv_isa_pkg::branch_f3_ok(w.b_view.funct3);

    // static prediction: backward taken, forward not taken
    assign take_branch = is_branch && imm_b[rv_isa_pkg::xlen-1];

    always_comb begin
        if (is_jal) begin
            next_pc = pc + imm_j;
        end else if (take_branch) begin
            next_pc = pc + imm_b;
        end else begin
            next_pc = pc + 32'd4; // fall through
        end
    end

    // exact encoding only, other system ops fall through
    assign is_ebreak = (inst_word == rv_isa_pkg::ebreak_inst);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= reset_pc;
        end else if (advance) begin
            pc <= next_pc;
        end
    end

endmodule

// File: inst_sram.sv
module inst_sram #(
    parameter logic [bus_pkg::addr_w-1:0] mem_base     = 32'h8000_0000,
    parameter int                         mem_words    = 64, // at least 2
    parameter int                         sram_latency = 3   // at least 1
) (
    input  logic                          clk,
    input  logic                          rst,
    // read address channel
    input  logic [bus_pkg::addr_w-1:0]    araddr,
    input  logic                          arvalid,
    output logic                          arready,
    // read data channel
    output logic                          rvalid,
    input  logic                          rready,
    output logic [bus_pkg::data_w-1:0]    rdata,
    output logic [bus_pkg::resp_w-1:0]    rresp,
    // preload strobe
    input  logic                          load_en,
    input  logic [bus_pkg::addr_w-1:0]    load_addr,
    input  logic [bus_pkg::data_w-1:0]    load_data
);

    localparam int idx_w = $clog2(mem_words);
    localparam int cnt_w = $clog2(sram_latency + 1);
    localparam logic [bus_pkg::addr_w-1:0] span = bus_pkg::addr_w'(mem_words * 4);

    logic [bus_pkg::data_w-1:0] mem [mem_words];

    logic [bus_pkg::addr_w-1:0] raddr;    // captured on address transfer
    logic [bus_pkg::addr_w-1:0] rd_off;
    logic [bus_pkg::addr_w-1:0] ld_off;
    logic [idx_w-1:0]           rd_idx;
    logic [idx_w-1:0]           ld_idx;
    logic                       rd_hit;
    logic                       ld_hit;
    logic [cnt_w-1:0]           cnt;      // cycles left before rvalid
    logic                       ar_fire;
    logic                       r_fire;

    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    // below-base addresses wrap to a huge offset and miss too
    assign rd_off = raddr - mem_base;
    assign rd_hit = (rd_off < span) && (raddr[1:0] == 2'b00);
    assign rd_idx = rd_off[idx_w+1:2];

    assign ld_off = load_addr - mem_base;
    assign ld_hit = (ld_off < span) && (load_addr[1:0] == 2'b00);
    assign ld_idx = ld_off[idx_w+1:2];

    // handshake control
    always_ff @(posedge clk) begin
        if (rst) begin
            arready <= 1'b1;
            rvalid  <= 1'b0;
            cnt     <= '0;
        end else begin
            if (ar_fire) begin
                arready <= 1'b0; // one read in flight
                cnt     <= cnt_w'(sram_latency);
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end
            if (cnt == cnt_w'(1)) begin
                rvalid <= 1'b1; // lands sram_latency edges after acceptance
            end else if (r_fire) begin
                rvalid  <= 1'b0;
                arready <= 1'b1; // reopen the address channel
            end
        end
    end

    // address and read payload
    always_ff @(posedge clk) begin
        if (ar_fire) raddr <= araddr;
        if (cnt == cnt_w'(1)) begin
            rdata <= rd_hit ? mem[rd_idx] : '0;
            rresp <= rd_hit ? bus_pkg::resp_okay : bus_pkg::resp_slverr;
        end
    end

    // preload, same base offset as reads
    always_ff @(posedge clk) begin
        if (load_en && ld_hit) mem[ld_idx] <= load_data;
    end

endmodule

// File: fetch_ctrl.sv
module fetch_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,      // one-cycle kick after loading
    // read address channel
    output logic [bus_pkg::addr_w-1:0]    araddr,
    output logic                          arvalid,
    input  logic                          arready,
    // read data channel
    input  logic                          rvalid,
    output logic                          rready,
    input  logic [bus_pkg::data_w-1:0]    rdata,
    input  logic [bus_pkg::resp_w-1:0]    rresp,
    // next-pc unit
    input  logic [rv_isa_pkg::xlen-1:0]   pc,
    input  logic                          is_ebreak,
    output logic [rv_isa_pkg::xlen-1:0]   inst_word,  // held word, decoded by next_pc_unit
    output logic                          advance,
    // downstream strobe, no back-pressure
    output logic                          inst_valid,
    output logic [rv_isa_pkg::xlen-1:0]   inst_pc,
    output logic [rv_isa_pkg::xlen-1:0]   inst,
    output logic                          halted,
    output logic                          fault
);

    localparam logic [2:0] st_idle    = 3'd0;
    localparam logic [2:0] st_request = 3'd1; // arvalid up
    localparam logic [2:0] st_wait    = 3'd2; // rready up
    localparam logic [2:0] st_issue   = 3'd3; // strobe out
    localparam logic [2:0] st_halted  = 3'd4;
    localparam logic [2:0] st_faulted = 3'd5;

    logic [2:0] state;
    logic [2:0] state_nxt;
    logic       ar_fire;
    logic       r_fire;

    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (start) state_nxt = st_request;
            end
            st_request: begin
                if (ar_fire) state_nxt = st_wait; // address held until taken
            end
            st_wait: begin
                if (r_fire) begin
                    if (rresp == bus_pkg::resp_okay) state_nxt = st_issue;
                    else state_nxt = st_faulted;
                end
            end
            st_issue: begin
                // ebreak still goes out, then fetch stops
                state_nxt = is_ebreak ? st_halted : st_request;
            end
            st_halted, st_faulted: state_nxt = state; // sticky until reset
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) state <= st_idle;
        else state <= state_nxt;
    end

    // capture word and its pc on the data transfer
    always_ff @(posedge clk) begin
        if (r_fire) begin
            inst_word <= rdata;
            inst_pc   <= pc; // pc only moves on advance
        end
    end

    assign araddr  = pc;
    assign arvalid = (state == st_request);
    assign rready  = (state == st_wait);

    assign inst_valid = (state == st_issue);
    assign inst       = inst_word;
    assign advance    = (state == st_issue) && !is_ebreak; // pc stays on ebreak

    assign halted = (state == st_halted);
    assign fault  = (state == st_faulted);

endmodule

// File: bus_pkg.sv
package bus_pkg;

    // read-only lite bus between fetch and the instruction sram
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int resp_w = 2;

    // axi-style response codes, only two ever produced
    localparam logic [resp_w-1:0] resp_okay   = 2'b00;
    localparam logic [resp_w-1:0] resp_slverr = 2'b10; // bad or misaligned address

endpackage

// File: rv_isa_pkg.sv
package rv_isa_pkg;

    localparam int xlen = 32; // also the instruction width

    // major opcodes seen by predecode
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_system = 7'b1110011;

    // branch funct3 codes, 010 and 011 are reserved
    localparam logic [2:0] f3_beq   = 3'b000;
    localparam logic [2:0] f3_bne   = 3'b001;
    localparam logic [2:0] f3_blt   = 3'b100;
    localparam logic [2:0] f3_bge   = 3'b101;
    localparam logic [2:0] f3_bltu  = 3'b110;
    localparam logic [2:0] f3_bgeu  = 3'b111;
    localparam logic [2:0] f3_priv  = 3'b000; // ecall/ebreak group

    // imm=1, rs1=0, rd=0
    localparam logic [xlen-1:0] ebreak_inst = {12'h001, 5'd0, f3_priv, 5'd0, op_system};

    // one fetched word, two field layouts over the same 32 bits
    typedef union packed {
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_view;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1; // rd slot
            logic       imm11;  // rd slot lsb
            logic [6:0] opcode;
        } b_view;
    } inst_word_u;

    // sign-extended jal offset, bit 0 always zero
    function automatic logic [xlen-1:0] j_imm(inst_word_u w);
        return {{11{w.j_view.imm20}}, w.j_view.imm20, w.j_view.imm19_12,
                w.j_view.imm11, w.j_view.imm10_1, 1'b0};
    endfunction

    // sign-extended branch offset
    function automatic logic [xlen-1:0] b_imm(inst_word_u w);
        return {{19{w.b_view.imm12}}, w.b_view.imm12, w.b_view.imm11,
                w.b_view.imm10_5, w.b_view.imm4_1, 1'b0};
    endfunction

    function automatic logic branch_f3_ok(logic [2:0] f3);
        case (f3)
            f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu: return 1'b1;
            default: return 1'b0; // reserved codes never predicted
        endcase
    endfunction

endpackage
